// File: common/param_defs.sv
/* Shared widths, ALU, branch and load/store operation codes,
   and the packed structs passed between pipeline stages. */
`default_nettype none

package param_defs;

  localparam int DataWidth = 32;

  typedef logic [DataWidth-1:0] reg_data_t;
  typedef logic [4:0]           reg_addr_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_BEQZ, BR_BNEZ
  } br_op_t;

  // Five loads do not fit below the top bit, so LHU shares it with the stores.
  typedef enum logic [2:0] {
    LSU_LB  = 3'b000,
    LSU_LH  = 3'b001,
    LSU_LW  = 3'b010,
    LSU_LBU = 3'b011,
    LSU_LHU = 3'b100,
    LSU_SB  = 3'b101,
    LSU_SH  = 3'b110,
    LSU_SW  = 3'b111
  } lsu_op_t;

  typedef struct packed {
    reg_data_t pc;
    reg_data_t imm;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    logic      use_pc;     // Operand a is the pc instead of rs1.
    logic      use_imm;    // Operand b is the immediate instead of rs2.
    alu_op_t   alu_op;
    logic      br;
    br_op_t    br_op;
    logic      br_taken;   // Static prediction from the decoder.
    logic      compressed;
    logic      lsu;
    lsu_op_t   lsu_op;
    logic      rd_en;
  } p_id_ex_t;

  typedef struct packed {
    reg_data_t alu_res;
    reg_data_t store_data;
    reg_addr_t rd_addr;
    logic      rd_en;
    logic      lsu;
    lsu_op_t   lsu_op;
    logic      br;
    logic      br_taken;
    logic      compressed;
  } p_ex_mem_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    reg_data_t data;
  } wb_t;

endpackage : param_defs

`default_nettype wire

// File: ex_stage/bru.sv
/* Branch condition unit covering the eight compare codes. */
`timescale 1ns/1ps
`default_nettype none

module bru (
  input  logic                 en,
  input  param_defs::br_op_t   br_type,
  input  param_defs::reg_data_t a,
  input  param_defs::reg_data_t b,
  output logic                 out
);
  import param_defs::*;

  always_comb begin
    out = 1'b0;
    if (en) begin
      case (br_type)
        BR_BEQ:  out = (a == b);
        BR_BNE:  out = (a != b);
        BR_BLT:  out = ($signed(a) < $signed(b));
        BR_BGE:  out = ($signed(a) >= $signed(b));
        BR_BLTU: out = (a < b);
        BR_BGEU: out = (a >= b);
        BR_BEQZ: out = (a == '0);   // Zero forms ignore operand b.
        BR_BNEZ: out = (a != '0);
        default: out = 1'b0;
      endcase
    end
  end

endmodule : bru

`default_nettype wire

// File: ex_stage/alu.sv
/* Integer ALU for the RV32I register and immediate operations. */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  param_defs::reg_data_t a,
  input  param_defs::reg_data_t b,
  input  param_defs::alu_op_t   alu_op,
  output param_defs::reg_data_t res
);
  import param_defs::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  always_comb begin
    case (alu_op)
      ALU_ADD:   res = a + b;
      ALU_SUB:   res = a - b;
      ALU_SLL:   res = a << shamt;
      ALU_SLT:   res = {{(DataWidth-1){1'b0}}, lt_signed};
      ALU_SLTU:  res = {{(DataWidth-1){1'b0}}, lt_unsigned};
      ALU_XOR:   res = a ^ b;
      ALU_SRL:   res = a >> shamt;
      ALU_SRA:   res = reg_data_t'($signed(a) >>> shamt);
      ALU_OR:    res = a | b;
      ALU_AND:   res = a & b;
      ALU_PASSB: res = b;           // Used by lui.
      default:   res = '0;
    endcase
  end

endmodule : alu

`default_nettype wire

// File: ex_stage/ex_stage.sv
/* Execute stage with operand selection, branch resolution
   against the static prediction, and the EX/MEM register. */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  param_defs::reg_data_t rs1_data,
  input  param_defs::reg_data_t rs2_data,
  input  param_defs::p_id_ex_t  p_id_ex,
  output param_defs::p_ex_mem_t p_ex_mem,
  output logic                  should_br,
  output logic                  br_mispredictd
);
  import param_defs::*;

  reg_data_t op_a;
  reg_data_t op_b;
  reg_data_t alu_out;
  reg_data_t fall_through;
  logic      bru_out;
  logic      should_br_next;
  p_ex_mem_t ex_mem_next;

  assign op_a = p_id_ex.use_pc  ? p_id_ex.pc  : rs1_data;
  assign op_b = p_id_ex.use_imm ? p_id_ex.imm : rs2_data;

  bru u_bru (
    .en     (p_id_ex.br),
    .br_type(p_id_ex.br_op),
    .a      (rs1_data),
    .b      (rs2_data),
    .out    (bru_out)
  );

  alu u_alu (
    .a     (op_a),
    .b     (op_b),
    .alu_op(p_id_ex.alu_op),
    .res   (alu_out)
  );

  assign fall_through   = p_id_ex.pc + (p_id_ex.compressed ? DataWidth'(2) : DataWidth'(4));
  assign should_br_next = p_id_ex.br && !p_id_ex.br_taken && bru_out;  // Late taken.
  assign br_mispredictd = p_id_ex.br && p_id_ex.br_taken && !bru_out;

  always_comb begin
    ex_mem_next.alu_res    = br_mispredictd ? fall_through : alu_out;
    ex_mem_next.store_data = rs2_data;
    ex_mem_next.rd_addr    = p_id_ex.rd_addr;
    ex_mem_next.rd_en      = p_id_ex.rd_en;
    ex_mem_next.lsu        = p_id_ex.lsu;
    ex_mem_next.lsu_op     = p_id_ex.lsu_op;
    ex_mem_next.br         = p_id_ex.br;
    ex_mem_next.br_taken   = p_id_ex.br_taken;
    ex_mem_next.compressed = p_id_ex.compressed;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p_ex_mem  <= '0;
      should_br <= 1'b0;
    end else begin
      p_ex_mem  <= ex_mem_next;
      should_br <= should_br_next;
    end
  end

endmodule : ex_stage

`default_nettype wire

// File: verilog/reg_file.sv
/* Register file with 31 writable registers, two combinational
   read ports and one write port; x0 always reads as zero. */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                  clk,
  input  logic                  rst_n,
  input  param_defs::reg_addr_t rs1_addr,
  input  param_defs::reg_addr_t rs2_addr,
  output param_defs::reg_data_t rs1_data,
  output param_defs::reg_data_t rs2_data,
  input  param_defs::wb_t       wb
);
  import param_defs::*;

  reg_data_t regs [31:1];

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && wb.addr != '0) begin
      regs[wb.addr] <= wb.data;   // Writes to x0 are dropped.
    end
  end

endmodule : reg_file

`default_nettype wire

// File: verilog/mem_wb_stage.sv
/* Memory and writeback stage with a word-addressed data RAM,
   load lane extraction and extension, store lane merge. */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage #(
  parameter int DmemWords = 256
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  param_defs::p_ex_mem_t p_ex_mem,
  output param_defs::wb_t       wb
);
  import param_defs::*;

  localparam int IdxW = $clog2(DmemWords);

  reg_data_t       dmem [DmemWords];
  logic [IdxW-1:0] word_idx;
  logic [1:0]      byte_off;
  logic            is_store;
  reg_data_t       rd_word;
  reg_data_t       st_word;
  reg_data_t       load_data;
  logic [7:0]      ld_byte;
  logic [15:0]     ld_half;

  assign word_idx = IdxW'(p_ex_mem.alu_res[DataWidth-1:2] % DmemWords);
  assign byte_off = p_ex_mem.alu_res[1:0];   // Misaligned halfword and word bits are ignored.
  assign is_store = p_ex_mem.lsu && (p_ex_mem.lsu_op inside {LSU_SB, LSU_SH, LSU_SW});

  assign rd_word = dmem[word_idx];
  assign ld_byte = rd_word[{byte_off, 3'b000} +: 8];
  assign ld_half = rd_word[{byte_off[1], 4'b0000} +: 16];

  always_comb begin
    case (p_ex_mem.lsu_op)
      LSU_LB:  load_data = {{(DataWidth-8){ld_byte[7]}}, ld_byte};
      LSU_LBU: load_data = {{(DataWidth-8){1'b0}}, ld_byte};
      LSU_LH:  load_data = {{(DataWidth-16){ld_half[15]}}, ld_half};
      LSU_LHU: load_data = {{(DataWidth-16){1'b0}}, ld_half};
      default: load_data = rd_word;
    endcase
  end

  always_comb begin
    st_word = rd_word;
    case (p_ex_mem.lsu_op)
      LSU_SB:  st_word[{byte_off, 3'b000} +: 8] = p_ex_mem.store_data[7:0];
      LSU_SH:  st_word[{byte_off[1], 4'b0000} +: 16] = p_ex_mem.store_data[15:0];
      LSU_SW:  st_word = p_ex_mem.store_data;
      default: st_word = rd_word;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DmemWords; i++) begin
        dmem[i] <= '0;
      end
    end else if (is_store) begin
      dmem[word_idx] <= st_word;
    end
  end

  assign wb.en   = p_ex_mem.rd_en && !is_store;
  assign wb.addr = p_ex_mem.rd_addr;
  assign wb.data = (p_ex_mem.lsu && !is_store) ? load_data : p_ex_mem.alu_res;

endmodule : mem_wb_stage

`default_nettype wire

// File: verilog/ex_top.sv
/* Back half of the pipeline: register file, execute stage
   and memory/writeback stage. */
`timescale 1ns/1ps
`default_nettype none

module ex_top #(
  parameter int DmemWords = 256
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  param_defs::p_id_ex_t  p_id_ex,
  output logic                  should_br,
  output logic                  br_mispredictd,
  output param_defs::reg_data_t redirect_pc,
  output param_defs::wb_t       wb
);
  import param_defs::*;

  reg_data_t rs1_data;
  reg_data_t rs2_data;
  p_ex_mem_t p_ex_mem;

  reg_file u_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1_addr(p_id_ex.rs1_addr),
    .rs2_addr(p_id_ex.rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .wb      (wb)
  );

  ex_stage u_ex_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .p_id_ex       (p_id_ex),
    .p_ex_mem      (p_ex_mem),
    .should_br     (should_br),
    .br_mispredictd(br_mispredictd)
  );

  mem_wb_stage #(
    .DmemWords(DmemWords)
  ) u_mem_wb_stage (
    .clk     (clk),
    .rst_n   (rst_n),
    .p_ex_mem(p_ex_mem),
    .wb      (wb)
  );

  assign redirect_pc = p_ex_mem.alu_res;   // Branch target while should_br is high.

endmodule : ex_top

`default_nettype wire

// File: sim/ex_checks.svh
/* Instruction builders, the issue-and-capture task and the
   compare tasks used by the ex_top testbench. */
`ifndef EX_CHECKS_SVH
`define EX_CHECKS_SVH

function automatic p_id_ex_t make_op(alu_op_t op, reg_addr_t rd, reg_addr_t rs1,
                                     reg_addr_t rs2, reg_data_t imm, logic use_imm);
  p_id_ex_t ins;
  ins          = '0;
  ins.alu_op   = op;
  ins.rd_addr  = rd;
  ins.rs1_addr = rs1;
  ins.rs2_addr = rs2;
  ins.imm      = imm;
  ins.use_imm  = use_imm;
  ins.rd_en    = 1'b1;
  return ins;
endfunction

// Branches compute pc+imm in the ALU and compare rs1 against rs2.
function automatic p_id_ex_t make_br(br_op_t op, reg_addr_t rs1, reg_addr_t rs2,
                                     reg_data_t pc, reg_data_t imm, logic pred, logic compr);
  p_id_ex_t ins;
  ins            = make_op(ALU_ADD, 5'd0, rs1, rs2, imm, 1'b1);
  ins.rd_en      = 1'b0;
  ins.pc         = pc;
  ins.use_pc     = 1'b1;
  ins.br         = 1'b1;
  ins.br_op      = op;
  ins.br_taken   = pred;
  ins.compressed = compr;
  return ins;
endfunction

// Stores keep rd_en set, so the stage itself has to drop their writeback.
function automatic p_id_ex_t make_mem(lsu_op_t op, reg_addr_t rd, reg_addr_t base,
                                      reg_addr_t src, reg_data_t off);
  p_id_ex_t ins;
  ins        = make_op(ALU_ADD, rd, base, src, off, 1'b1);
  ins.lsu    = 1'b1;
  ins.lsu_op = op;
  return ins;
endfunction

// Issues one instruction followed by two bubbles and captures its results.
task automatic exec(input p_id_ex_t ins, output wb_t wb_o, output logic sb_o,
                    output reg_data_t rpc_o, output logic mp_o);
  int   n;
  logic want_wb;
  want_wb = ins.rd_en && !(ins.lsu && (ins.lsu_op inside {LSU_SB, LSU_SH, LSU_SW}));
  @(negedge clk);
  p_id_ex = ins;
  #5 mp_o = br_mispredictd;   // Combinational flag, sampled mid low phase.
  n = 0;
  do begin
    @(negedge clk);
    p_id_ex = '0;
    n++;
  end while (want_wb && !wb.en && n < 4);
  if (want_wb && (!wb.en || n != 1)) begin
    checks++;
    errors++;
    $display("Writeback for rd %0d did not appear one cycle after issue", ins.rd_addr);
  end
  wb_o  = wb;
  sb_o  = should_br;
  rpc_o = redirect_pc;
  @(negedge clk);
endtask

task automatic check_wb(input string name, input wb_t got, input wb_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAIL %s got en=%h addr=%h data=%h, expected en=%h addr=%h data=%h",
             name, got.en, got.addr, got.data, exp.en, exp.addr, exp.data);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAIL %s got %h, expected %h", name, got, exp);
  end
endtask

task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAIL %s got %h, expected %h", name, got, exp);
  end
endtask

`endif

// File: sim/tb_ex_top.sv
/* Testbench top for ex_top: clock, reset, DUT, LFSR source,
   reference model and the directed tests. */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;
  import param_defs::*;

  localparam int DmemWords = 256;
  localparam int MaxCycles = 5000;

  logic        clk;
  logic        rst_n;
  p_id_ex_t    p_id_ex;
  logic        should_br;
  logic        br_mispredictd;
  reg_data_t   redirect_pc;
  wb_t         wb;
  logic [31:0] lfsr;
  int          checks;
  int          errors;

  ex_top #(
    .DmemWords(DmemWords)
  ) uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .p_id_ex       (p_id_ex),
    .should_br     (should_br),
    .br_mispredictd(br_mispredictd),
    .redirect_pc   (redirect_pc),
    .wb            (wb)
  );

  `include "ex_checks.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);   // Right-shifting Galois form.
  endfunction

  task automatic rand_bits(input int n, output reg_data_t w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      w    = {w[DataWidth-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic reg_data_t model_alu(alu_op_t op, reg_data_t a, reg_data_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ALU_ADD:   return a + b;
      ALU_SUB:   return a + ~b + 32'd1;
      ALU_SLL:   return a << sh;
      ALU_SLT:   return {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
      ALU_SLTU:  return {31'd0, a < b};
      ALU_XOR:   return a ^ b;
      ALU_SRL:   return a >> sh;
      ALU_SRA:   return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      ALU_OR:    return a | b;
      ALU_AND:   return a & b;
      ALU_PASSB: return b;
      default:   return '0;
    endcase
  endfunction

  function automatic logic model_br(br_op_t op, reg_data_t a, reg_data_t b);
    logic lt_s;
    lt_s = (a[31] != b[31]) ? a[31] : (a < b);   // Differing signs decide alone.
    case (op)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return lt_s;
      BR_BGE:  return !lt_s;
      BR_BLTU: return a < b;
      BR_BGEU: return !(a < b);
      BR_BEQZ: return a == '0;
      BR_BNEZ: return a != '0;
      default: return 1'b0;
    endcase
  endfunction

  function automatic reg_data_t model_load(lsu_op_t op, reg_data_t w, logic [1:0] off);
    logic [7:0]  by;
    logic [15:0] hw;
    by = 8'(w >> {off, 3'b000});
    hw = 16'(w >> {off[1], 4'b0000});
    case (op)
      LSU_LB:  return {{24{by[7]}}, by};
      LSU_LBU: return {24'h0, by};
      LSU_LH:  return {{16{hw[15]}}, hw};
      LSU_LHU: return {16'h0, hw};
      default: return w;
    endcase
  endfunction

  function automatic reg_data_t model_store(lsu_op_t op, reg_data_t w, reg_data_t d,
                                            logic [1:0] off);
    reg_data_t m;
    reg_data_t v;
    case (op)
      LSU_SB: begin
        m = 32'h0000_00ff << {off, 3'b000};
        v = {4{d[7:0]}};
      end
      LSU_SH: begin
        m = 32'h0000_ffff << {off[1], 4'b0000};
        v = {2{d[15:0]}};
      end
      default: begin
        m = 32'hffff_ffff;
        v = d;
      end
    endcase
    return (w & ~m) | (v & m);
  endfunction

  task automatic report(input string name, input int start);
    $display("%-22s %0d errors", name, errors - start);
  endtask

  task automatic test_reset_x0();
    wb_t       got;
    logic      sb;
    logic      mp;
    reg_data_t rpc;
    reg_data_t v;
    int        start;
    start = errors;
    check_flag("wb.en", wb.en, 1'b0);
    check_flag("should_br", should_br, 1'b0);
    exec(make_op(ALU_PASSB, 5'd9, 5'd0, 5'd9, '0, 1'b0), got, sb, rpc, mp);
    check_data("wb.data", got.data, '0);   // Register file cleared by reset.
    rand_bits(32, v);
    exec(make_op(ALU_PASSB, 5'd0, 5'd0, 5'd0, v, 1'b1), got, sb, rpc, mp);
    check_wb("wb", got, {1'b1, 5'd0, v});
    exec(make_op(ALU_PASSB, 5'd10, 5'd0, 5'd0, '0, 1'b0), got, sb, rpc, mp);
    check_data("wb.data", got.data, '0);
    report("reset and x0", start);
  endtask

  task automatic test_alu();
    wb_t       got;
    logic      sb;
    logic      mp;
    reg_data_t rpc;
    reg_data_t a;
    reg_data_t b;
    reg_data_t exp;
    int        start;
    start = errors;
    rand_bits(32, a);
    rand_bits(32, b);
    exec(make_op(ALU_PASSB, 5'd1, 5'd0, 5'd0, a, 1'b1), got, sb, rpc, mp);
    check_wb("wb", got, {1'b1, 5'd1, a});
    exec(make_op(ALU_PASSB, 5'd2, 5'd0, 5'd0, b, 1'b1), got, sb, rpc, mp);
    check_wb("wb", got, {1'b1, 5'd2, b});
    for (int i = 0; i < 11; i++) begin
      exp = model_alu(alu_op_t'(i), a, b);
      exec(make_op(alu_op_t'(i), 5'd3, 5'd1, 5'd2, '0, 1'b0), got, sb, rpc, mp);
      check_wb("wb", got, {1'b1, 5'd3, exp});
      exec(make_op(ALU_PASSB, 5'd4, 5'd0, 5'd3, '0, 1'b0), got, sb, rpc, mp);
      check_data("wb.data", got.data, exp);
    end
    report("alu ops", start);
  endtask

  task automatic test_branches(input logic pred);
    wb_t       got;
    logic      sb;
    logic      mp;
    logic      cond;
    reg_data_t rpc;
    reg_data_t a;
    reg_data_t b;
    reg_data_t pc;
    reg_data_t imm;
    reg_data_t tmp;
    int        start;
    start = errors;
    for (int c = 0; c < 3; c++) begin
      rand_bits(32, a);
      rand_bits(32, b);
      if (c == 1) b = a;    // Equal operands.
      if (c == 2) a = '0;   // Zero operand.
      exec(make_op(ALU_PASSB, 5'd1, 5'd0, 5'd0, a, 1'b1), got, sb, rpc, mp);
      exec(make_op(ALU_PASSB, 5'd2, 5'd0, 5'd0, b, 1'b1), got, sb, rpc, mp);
      for (int i = 0; i < 8; i++) begin
        rand_bits(32, pc);
        rand_bits(32, imm);
        rand_bits(1, tmp);
        pc[0] = 1'b0;
        cond  = model_br(br_op_t'(i), a, b);
        exec(make_br(br_op_t'(i), 5'd1, 5'd2, pc, imm, pred, tmp[0]), got, sb, rpc, mp);
        check_flag("should_br", sb, !pred && cond);
        check_flag("br_mispredictd", mp, pred && !cond);
        if (!pred && cond) check_data("redirect_pc", rpc, pc + imm);
        if (pred && !cond) check_data("redirect_pc", rpc, pc + (tmp[0] ? 32'd2 : 32'd4));
      end
    end
    report(pred ? "branches predicted" : "branches not predicted", start);
  endtask

  task automatic test_mem();
    wb_t        got;
    logic       sb;
    logic       mp;
    reg_data_t  rpc;
    reg_data_t  addr;
    reg_data_t  w;
    reg_data_t  d;
    reg_data_t  tmp;
    reg_data_t  word;
    logic [1:0] hoff;
    lsu_op_t    ld_ops [5];
    int         start;
    start  = errors;
    ld_ops = '{LSU_LB, LSU_LBU, LSU_LH, LSU_LHU, LSU_LW};
    rand_bits(32, addr);
    rand_bits(32, w);
    rand_bits(32, d);
    rand_bits(2, tmp);
    addr[1:0] = 2'b00;
    hoff      = tmp[1] ? 2'd0 : 2'd2;   // Halfword goes to the half without the byte.
    exec(make_op(ALU_PASSB, 5'd5, 5'd0, 5'd0, addr, 1'b1), got, sb, rpc, mp);
    exec(make_op(ALU_PASSB, 5'd6, 5'd0, 5'd0, w, 1'b1), got, sb, rpc, mp);
    exec(make_op(ALU_PASSB, 5'd7, 5'd0, 5'd0, d, 1'b1), got, sb, rpc, mp);
    exec(make_op(ALU_PASSB, 5'd9, 5'd0, 5'd0, addr + DmemWords * 4, 1'b1), got, sb, rpc, mp);
    exec(make_mem(LSU_SW, 5'd0, 5'd5, 5'd6, '0), got, sb, rpc, mp);
    check_flag("wb.en", got.en, 1'b0);
    exec(make_mem(LSU_SB, 5'd0, 5'd5, 5'd7, {30'd0, tmp[1:0]}), got, sb, rpc, mp);
    check_flag("wb.en", got.en, 1'b0);
    exec(make_mem(LSU_SH, 5'd0, 5'd5, 5'd7, {30'd0, hoff}), got, sb, rpc, mp);
    check_flag("wb.en", got.en, 1'b0);
    word = model_store(LSU_SW, 32'h0, w, 2'd0);
    word = model_store(LSU_SB, word, d, tmp[1:0]);
    word = model_store(LSU_SH, word, d, hoff);
    for (int off = 0; off < 4; off++) begin
      for (int k = 0; k < 5; k++) begin
        exec(make_mem(ld_ops[k], 5'd8, 5'd5, 5'd0, {30'd0, off[1:0]}), got, sb, rpc, mp);
        check_wb("wb", got, {1'b1, 5'd8, model_load(ld_ops[k], word, off[1:0])});
      end
    end
    exec(make_mem(LSU_LW, 5'd8, 5'd9, 5'd0, '0), got, sb, rpc, mp);
    check_wb("wb", got, {1'b1, 5'd8, word});   // Address wraps modulo the RAM depth.
    report("loads and stores", start);
  endtask

  initial begin
    repeat (MaxCycles) @(posedge clk);
    $display("Timeout: test sequence still running after %0d cycles", MaxCycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    rst_n   = 1'b0;
    p_id_ex = '0;
    lfsr    = 32'hb106_88a1;
    checks  = 0;
    errors  = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_x0();
    test_alu();
    test_branches(1'b0);
    test_branches(1'b1);
    test_mem();
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_ex_top

`default_nettype wire

// File: flist.f
+incdir+sim
common/param_defs.sv
ex_stage/bru.sv
ex_stage/alu.sv
ex_stage/ex_stage.sv
verilog/reg_file.sv
verilog/mem_wb_stage.sv
verilog/ex_top.sv
sim/tb_ex_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the ex_top testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps --top-module tb_ex_top -f flist.f -o tb_ex_top

output=$(./obj_dir/tb_ex_top)
echo "$output"

if grep -qF "Simulation finished: PASS" <<< "$output"; then
  exit 0
fi
exit 1
